//--- calc_pkg.sv
// Number format, operator codes and controller states shared by the calculator RTL and testbench
`default_nettype none

package calc_pkg;

    // Word layout
    localparam int NUM_W = 16;
    localparam int MAG_W = NUM_W - 1;

    // Keypad digit width, one BCD digit per key
    localparam int DIGIT_W = 4;

    // One multiplier iteration per magnitude bit
    localparam int MULT_CYCLES = MAG_W;

    // Sign-magnitude number, bit 15 is the sign
    typedef struct packed {
        logic             sign;
        logic [MAG_W-1:0] mag;
    } calc_num_t;

    // Multiplicand used to shift an operand one decimal place
    localparam calc_num_t NUM_TEN = '{sign: 1'b0, mag: MAG_W'(10)};

    // Operator keys, codes 5 to 7 unused
    typedef enum logic [2:0] {
        OP_NONE = 3'd0,
        OP_NEG  = 3'd1,
        OP_ADD  = 3'd2,
        OP_SUB  = 3'd3,
        OP_MUL  = 3'd4
    } calc_op_t;

    // Controller FSM
    typedef enum logic [3:0] {
        ST_ENTRY1,
        ST_WAIT_MUL1,
        ST_ADD_DIGIT1,
        ST_ENTRY2,
        ST_WAIT_MUL2,
        ST_ADD_DIGIT2,
        ST_LAUNCH,
        ST_WAIT_RESULT,
        ST_SHOW_RESULT
    } calc_state_t;

endpackage

`default_nettype wire

//--- sign_mag_adder.sv
// Two-cycle sign-magnitude adder/subtractor, started by a pulse and answering with a finish pulse
`timescale 1ns/100ps
`default_nettype none

module sign_mag_adder (
    input  logic                clk,
    input  logic                nRST,
    input  calc_pkg::calc_num_t a,
    input  calc_pkg::calc_num_t b,
    input  logic                sub,
    input  logic                start,
    output calc_pkg::calc_num_t result,
    output logic                finish
);

    // First stage, operands with effective sign of b
    logic [calc_pkg::MAG_W-1:0] s1_a_mag;
    logic [calc_pkg::MAG_W-1:0] s1_b_mag;
    logic                       s1_a_sign;
    logic                       s1_b_sign;
    logic                       s1_a_ge_b;
    logic                       s1_valid;

    logic [calc_pkg::MAG_W-1:0] sum_mag;
    logic                       sum_sign;

    always_comb begin
        if (s1_a_sign == s1_b_sign) begin
            // Same sign, wraps modulo 2^15
            sum_mag  = s1_a_mag + s1_b_mag;
            sum_sign = s1_a_sign;
        end else if (s1_a_ge_b) begin
            sum_mag  = s1_a_mag - s1_b_mag;
            sum_sign = s1_a_sign;
        end else begin
            sum_mag  = s1_b_mag - s1_a_mag;
            sum_sign = s1_b_sign;
        end
    end

    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            s1_valid <= 1'b0;
            finish   <= 1'b0;
        end else begin
            s1_valid <= start;
            finish   <= s1_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            s1_a_mag  <= a.mag;
            s1_b_mag  <= b.mag;
            s1_a_sign <= a.sign;
            s1_b_sign <= b.sign ^ sub;
            s1_a_ge_b <= (a.mag >= b.mag);
        end
        if (s1_valid) begin
            result.mag  <= sum_mag;
            // Zero is always positive
            result.sign <= sum_sign && (sum_mag != '0);
        end
    end

endmodule

`default_nettype wire

//--- shift_add_multiplier.sv
// Sequential shift-and-add multiplier for sign-magnitude numbers, product wraps modulo 2^15
`timescale 1ns/100ps
`default_nettype none

module shift_add_multiplier (
    input  logic                clk,
    input  logic                nRST,
    input  calc_pkg::calc_num_t a,
    input  calc_pkg::calc_num_t b,
    input  logic                start,
    output calc_pkg::calc_num_t result,
    output logic                finish
);

    logic                                     busy;
    logic                                     done;
    logic [$clog2(calc_pkg::MULT_CYCLES)-1:0] iter_cnt;

    logic [calc_pkg::MAG_W-1:0] mcand;
    logic [calc_pkg::MAG_W-1:0] mplier;
    logic [calc_pkg::MAG_W-1:0] prod;
    logic                       prod_sign;

    // Iteration control
    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            busy     <= 1'b0;
            done     <= 1'b0;
            iter_cnt <= '0;
        end else begin
            done <= 1'b0;
            if (start) begin
                busy     <= 1'b1;
                iter_cnt <= '0;
            end else if (busy) begin
                iter_cnt <= iter_cnt + 1'b1;
                if (int'(iter_cnt) == calc_pkg::MULT_CYCLES - 1) begin
                    busy <= 1'b0;
                    done <= 1'b1;
                end
            end
        end
    end

    // Datapath, one multiplier bit per cycle
    always_ff @(posedge clk) begin
        if (start) begin
            mcand     <= a.mag;
            mplier    <= b.mag;
            prod      <= '0;
            prod_sign <= a.sign ^ b.sign;
        end else if (busy) begin
            if (mplier[0]) begin
                prod <= prod + mcand;
            end
            mcand  <= mcand << 1;
            mplier <= mplier >> 1;
        end
    end

    // Final cycle, sign applied and forced positive on a zero product
    assign result = '{sign: prod_sign && (prod != '0), mag: prod};
    assign finish = done;

endmodule

`default_nettype wire

//--- calc_controller.sv
// Keypad calculator FSM: builds both operands digit by digit and runs the adder or multiplier
`timescale 1ns/100ps
`default_nettype none

module calc_controller (
    input  logic                          clk,
    input  logic                          nRST,
    input  logic [calc_pkg::DIGIT_W-1:0]  keypad_digit,
    input  logic                          key_read,
    input  calc_pkg::calc_op_t            operator_code,
    input  logic                          equal_key,

    output calc_pkg::calc_num_t           add_a,
    output calc_pkg::calc_num_t           add_b,
    output logic                          add_sub,
    output logic                          add_start,
    input  calc_pkg::calc_num_t           add_result,
    input  logic                          add_finish,

    output calc_pkg::calc_num_t           mul_a,
    output calc_pkg::calc_num_t           mul_b,
    output logic                          mul_start,
    input  calc_pkg::calc_num_t           mul_result,
    input  logic                          mul_finish,

    output calc_pkg::calc_num_t           display,
    output logic                          complete
);

    calc_pkg::calc_state_t state;
    calc_pkg::calc_op_t    op_latched;

    calc_pkg::calc_num_t operand1;
    calc_pkg::calc_num_t operand2;

    logic [calc_pkg::DIGIT_W-1:0] digit;
    logic [calc_pkg::MAG_W-1:0]   digit_ext;

    assign digit_ext = {{(calc_pkg::MAG_W - calc_pkg::DIGIT_W){1'b0}}, digit};

    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            state      <= calc_pkg::ST_ENTRY1;
            op_latched <= calc_pkg::OP_NONE;
            operand1   <= '0;
            operand2   <= '0;
            display    <= '0;
            complete   <= 1'b0;
            add_start  <= 1'b0;
            mul_start  <= 1'b0;
        end else begin
            add_start <= 1'b0;
            mul_start <= 1'b0;
            complete  <= 1'b0;

            case (state)
                calc_pkg::ST_ENTRY1: begin
                    if (key_read) begin
                        mul_start <= 1'b1;
                        state     <= calc_pkg::ST_WAIT_MUL1;
                    end else if (operator_code == calc_pkg::OP_NEG) begin
                        operand1.sign <= ~operand1.sign;
                    end else if (operator_code inside {calc_pkg::OP_ADD, calc_pkg::OP_SUB,
                                                       calc_pkg::OP_MUL}) begin
                        op_latched <= operator_code;
                        state      <= calc_pkg::ST_ENTRY2;
                    end
                end

                // Operand times ten, sign kept
                calc_pkg::ST_WAIT_MUL1: begin
                    if (mul_finish) begin
                        operand1.mag <= mul_result.mag;
                        state        <= calc_pkg::ST_ADD_DIGIT1;
                    end
                end

                calc_pkg::ST_ADD_DIGIT1: begin
                    operand1.mag <= operand1.mag + digit_ext;
                    state        <= calc_pkg::ST_ENTRY1;
                end

                calc_pkg::ST_ENTRY2: begin
                    if (equal_key) begin
                        state <= calc_pkg::ST_LAUNCH;
                    end else if (key_read) begin
                        mul_start <= 1'b1;
                        state     <= calc_pkg::ST_WAIT_MUL2;
                    end else if (operator_code == calc_pkg::OP_NEG) begin
                        operand2.sign <= ~operand2.sign;
                    end
                end

                calc_pkg::ST_WAIT_MUL2: begin
                    if (mul_finish) begin
                        operand2.mag <= mul_result.mag;
                        state        <= calc_pkg::ST_ADD_DIGIT2;
                    end
                end

                calc_pkg::ST_ADD_DIGIT2: begin
                    operand2.mag <= operand2.mag + digit_ext;
                    state        <= calc_pkg::ST_ENTRY2;
                end

                calc_pkg::ST_LAUNCH: begin
                    if (op_latched == calc_pkg::OP_MUL) begin
                        mul_start <= 1'b1;
                    end else begin
                        add_start <= 1'b1;
                    end
                    state <= calc_pkg::ST_WAIT_RESULT;
                end

                // Only the launched unit can finish here
                calc_pkg::ST_WAIT_RESULT: begin
                    if (add_finish) begin
                        display  <= add_result;
                        complete <= 1'b1;
                        state    <= calc_pkg::ST_SHOW_RESULT;
                    end else if (mul_finish) begin
                        display  <= mul_result;
                        complete <= 1'b1;
                        state    <= calc_pkg::ST_SHOW_RESULT;
                    end
                end

                // Next calculation starts from zero
                calc_pkg::ST_SHOW_RESULT: begin
                    operand1   <= '0;
                    operand2   <= '0;
                    op_latched <= calc_pkg::OP_NONE;
                    state      <= calc_pkg::ST_ENTRY1;
                end

                default: begin
                    state <= calc_pkg::ST_ENTRY1;
                end
            endcase
        end
    end

    // Operand registers for the units, held until their finish
    always_ff @(posedge clk) begin
        case (state)
            calc_pkg::ST_ENTRY1: begin
                if (key_read) begin
                    digit <= keypad_digit;
                    mul_a <= operand1;
                    mul_b <= calc_pkg::NUM_TEN;
                end
            end

            calc_pkg::ST_ENTRY2: begin
                if (key_read && !equal_key) begin
                    digit <= keypad_digit;
                    mul_a <= operand2;
                    mul_b <= calc_pkg::NUM_TEN;
                end
            end

            calc_pkg::ST_LAUNCH: begin
                add_a   <= operand1;
                add_b   <= operand2;
                add_sub <= (op_latched == calc_pkg::OP_SUB);
                mul_a   <= operand1;
                mul_b   <= operand2;
            end

            default: begin
            end
        endcase
    end

endmodule

`default_nettype wire

//--- calc_top.sv
// Calculator top level joining the controller to the adder and multiplier
`timescale 1ns/100ps
`default_nettype none

module calc_top (
    input  logic                         clk,
    input  logic                         nRST,
    input  logic [calc_pkg::DIGIT_W-1:0] keypad_digit,
    input  logic                         key_read,
    input  calc_pkg::calc_op_t           operator_code,
    input  logic                         equal_key,
    output calc_pkg::calc_num_t          display,
    output logic                         complete
);

    calc_pkg::calc_num_t add_a;
    calc_pkg::calc_num_t add_b;
    calc_pkg::calc_num_t add_result;
    logic                add_sub;
    logic                add_start;
    logic                add_finish;

    calc_pkg::calc_num_t mul_a;
    calc_pkg::calc_num_t mul_b;
    calc_pkg::calc_num_t mul_result;
    logic                mul_start;
    logic                mul_finish;

    calc_controller i_calc_controller (
        .clk           (clk),
        .nRST          (nRST),
        .keypad_digit  (keypad_digit),
        .key_read      (key_read),
        .operator_code (operator_code),
        .equal_key     (equal_key),
        .add_a         (add_a),
        .add_b         (add_b),
        .add_sub       (add_sub),
        .add_start     (add_start),
        .add_result    (add_result),
        .add_finish    (add_finish),
        .mul_a         (mul_a),
        .mul_b         (mul_b),
        .mul_start     (mul_start),
        .mul_result    (mul_result),
        .mul_finish    (mul_finish),
        .display       (display),
        .complete      (complete)
    );

    sign_mag_adder i_sign_mag_adder (
        .clk    (clk),
        .nRST   (nRST),
        .a      (add_a),
        .b      (add_b),
        .sub    (add_sub),
        .start  (add_start),
        .result (add_result),
        .finish (add_finish)
    );

    // Shared between digit entry and the multiply operation
    shift_add_multiplier i_shift_add_multiplier (
        .clk    (clk),
        .nRST   (nRST),
        .a      (mul_a),
        .b      (mul_b),
        .start  (mul_start),
        .result (mul_result),
        .finish (mul_finish)
    );

endmodule

`default_nettype wire

//--- tb_calc.sv
// Table-driven testbench for the keypad calculator; compile with the sources listed in verilog.f
`timescale 1ns/100ps
`default_nettype none

module tb_calc;

    localparam int CLK_PERIOD  = 100;
    localparam int KEY_GAP     = 24;
    localparam int ADD_LATENCY = 5;
    localparam int MUL_LATENCY = 19;
    localparam int NUM_RANDOM  = 8;
    localparam int MAG_MOD     = 1 << calc_pkg::MAG_W;

    // One calculation, operands as typed in decimal
    typedef struct packed {
        logic [16:0]         opnd_a;
        logic                neg_a;
        calc_pkg::calc_op_t  op;
        logic [16:0]         opnd_b;
        logic                neg_b;
        calc_pkg::calc_num_t expected;
    } calc_case_t;

    logic                         clk;
    logic                         nRST;
    logic [calc_pkg::DIGIT_W-1:0] keypad_digit;
    logic                         key_read;
    calc_pkg::calc_op_t           operator_code;
    logic                         equal_key;
    calc_pkg::calc_num_t          display;
    logic                         complete;

    calc_case_t          cases[$];
    calc_pkg::calc_num_t prev_display;
    logic [31:0]         lfsr_state;
    int                  watchdog_cycles;

    calc_top i_calc_top (
        .clk           (clk),
        .nRST          (nRST),
        .keypad_digit  (keypad_digit),
        .key_read      (key_read),
        .operator_code (operator_code),
        .equal_key     (equal_key),
        .display       (display),
        .complete      (complete)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #(CLK_PERIOD / 2) clk = ~clk;
        end
    end

    // Right-shifting Galois LFSR
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return (s >> 1) ^ (s[0] ? 32'hD000_0001 : 32'h0);
    endfunction

    task automatic take_bits(input int nbits, output int value);
        value = 0;
        for (int i = 0; i < nbits; i++) begin
            value      = (value << 1) | lfsr_state[0];
            lfsr_state = lfsr_next(lfsr_state);
        end
    endtask

    function automatic int count_digits(input int value);
        int n;
        n = 1;
        while (value >= 10) begin
            value = value / 10;
            n++;
        end
        return n;
    endfunction

    // Operand as the keypad builds it, times ten plus digit modulo 2^15
    function automatic calc_pkg::calc_num_t entered_value(input int value, input logic neg);
        calc_pkg::calc_num_t num;
        int                  p;
        int                  mag;
        p   = 1;
        mag = 0;
        while (p * 10 <= value) begin
            p = p * 10;
        end
        while (p > 0) begin
            mag = (mag * 10 + (value / p) % 10) % MAG_MOD;
            p   = p / 10;
        end
        num.sign = neg;
        num.mag  = mag[calc_pkg::MAG_W-1:0];
        return num;
    endfunction

    function automatic calc_pkg::calc_num_t expected_result(input calc_pkg::calc_num_t a,
                                                            input calc_pkg::calc_num_t b,
                                                            input calc_pkg::calc_op_t  op);
        calc_pkg::calc_num_t r;
        logic                b_sign;
        longint              mag;
        b_sign = b.sign ^ (op == calc_pkg::OP_SUB);
        if (op == calc_pkg::OP_MUL) begin
            mag    = (longint'(a.mag) * b.mag) % MAG_MOD;
            r.sign = a.sign ^ b.sign;
        end else if (a.sign == b_sign) begin
            mag    = (longint'(a.mag) + b.mag) % MAG_MOD;
            r.sign = a.sign;
        end else if (a.mag >= b.mag) begin
            mag    = a.mag - b.mag;
            r.sign = a.sign;
        end else begin
            mag    = b.mag - a.mag;
            r.sign = b_sign;
        end
        r.mag = mag[calc_pkg::MAG_W-1:0];
        // Zero is positive
        if (mag == 0) begin
            r.sign = 1'b0;
        end
        return r;
    endfunction

    function automatic calc_case_t make_case(input int a, input logic neg_a,
                                             input calc_pkg::calc_op_t op, input int b,
                                             input logic neg_b, input logic [15:0] expected);
        calc_case_t c;
        c.opnd_a   = a;
        c.neg_a    = neg_a;
        c.op       = op;
        c.opnd_b   = b;
        c.neg_b    = neg_b;
        c.expected = expected;
        return c;
    endfunction

    task automatic check_value(input string what, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("[ERROR] time %0t: %s is 0x%0h, expected 0x%0h",
                     $time, what, actual, expected);
            $display("sim failed");
            $fatal(1);
        end
    endtask

    // One keypad event, then idle until the next event slot
    task automatic press_key(input logic is_digit, input logic [3:0] digit,
                             input calc_pkg::calc_op_t op);
        @(posedge clk);
        if (is_digit) begin
            key_read     <= 1'b1;
            keypad_digit <= digit;
        end else begin
            operator_code <= op;
        end
        @(posedge clk);
        key_read      <= 1'b0;
        operator_code <= calc_pkg::OP_NONE;
        repeat (KEY_GAP - 2) @(posedge clk);
    endtask

    task automatic send_number(input int value);
        int p;
        p = 1;
        while (p * 10 <= value) begin
            p = p * 10;
        end
        while (p > 0) begin
            press_key(1'b1, 4'((value / p) % 10), calc_pkg::OP_NONE);
            p = p / 10;
        end
    endtask

    task automatic run_case(input calc_case_t c);
        int cycles;
        send_number(c.opnd_a);
        if (c.neg_a) begin
            press_key(1'b0, 4'h0, calc_pkg::OP_NEG);
        end
        press_key(1'b0, 4'h0, c.op);
        send_number(c.opnd_b);
        if (c.neg_b) begin
            press_key(1'b0, 4'h0, calc_pkg::OP_NEG);
        end
        // Previous result still shown
        @(negedge clk);
        check_value("display before equals", display, prev_display);
        @(posedge clk);
        equal_key <= 1'b1;
        cycles = 0;
        do begin
            @(posedge clk);
            equal_key <= 1'b0;
            cycles++;
            @(negedge clk);
        end while (!complete);
        check_value("cycles from equals to complete", cycles,
                    (c.op == calc_pkg::OP_MUL) ? MUL_LATENCY : ADD_LATENCY);
        check_value("display", display, c.expected);
        @(negedge clk);
        check_value("complete one cycle later", complete, 0);
        check_value("display one cycle later", display, c.expected);
        prev_display = c.expected;
    endtask

    initial begin
        calc_pkg::calc_op_t op;
        int                 a;
        int                 b;
        int                 na;
        int                 nb;
        int                 sel;
        int                 budget;
        nRST          = 1'b0;
        keypad_digit  = '0;
        key_read      = 1'b0;
        operator_code = calc_pkg::OP_NONE;
        equal_key     = 1'b0;
        prev_display  = '0;
        lfsr_state    = 32'h29f3e7b4;

        cases.push_back(make_case(123, 0, calc_pkg::OP_ADD, 456, 0, 16'h0243));
        cases.push_back(make_case(25, 0, calc_pkg::OP_SUB, 70, 0, 16'h802D));
        cases.push_back(make_case(70, 0, calc_pkg::OP_SUB, 70, 0, 16'h0000));
        cases.push_back(make_case(12, 1, calc_pkg::OP_MUL, 3, 0, 16'h8024));
        cases.push_back(make_case(12, 1, calc_pkg::OP_MUL, 3, 1, 16'h0024));
        cases.push_back(make_case(300, 0, calc_pkg::OP_MUL, 200, 0, 16'h6A60));
        cases.push_back(make_case(5, 0, calc_pkg::OP_ADD, 9, 1, 16'h8004));
        cases.push_back(make_case(7, 1, calc_pkg::OP_SUB, 7, 1, 16'h0000));
        cases.push_back(make_case(32767, 0, calc_pkg::OP_ADD, 1, 0, 16'h0000));
        // 40000 wraps while it is typed in
        cases.push_back(make_case(40000, 0, calc_pkg::OP_ADD, 0, 0, 16'h1C40));

        for (int i = 0; i < NUM_RANDOM; i++) begin
            take_bits(10, a);
            take_bits(1, na);
            take_bits(2, sel);
            take_bits(10, b);
            take_bits(1, nb);
            a  = a % 1000;
            b  = b % 1000;
            op = (sel == 0) ? calc_pkg::OP_ADD :
                 ((sel == 1) ? calc_pkg::OP_SUB : calc_pkg::OP_MUL);
            cases.push_back(make_case(a, na, op, b, nb,
                            expected_result(entered_value(a, na), entered_value(b, nb), op)));
        end

        // Budget for every key slot plus the result of each case
        budget = 20;
        foreach (cases[i]) begin
            budget += (count_digits(cases[i].opnd_a) + cases[i].neg_a + 1 +
                       count_digits(cases[i].opnd_b) + cases[i].neg_b + 2) * KEY_GAP +
                      MUL_LATENCY + 4;
        end
        watchdog_cycles = budget;

        repeat (4) @(posedge clk);
        nRST <= 1'b1;
        @(negedge clk);
        check_value("display after reset", display, 0);
        check_value("complete after reset", complete, 0);

        foreach (cases[i]) begin
            run_case(cases[i]);
        end

        $display("sim passed");
        $finish;
    end

    initial begin
        wait (watchdog_cycles != 0);
        repeat (watchdog_cycles) @(posedge clk);
        $display("Timeout after %0d cycles: complete never came", watchdog_cycles);
        $display("sim failed");
        $fatal(1);
    end

endmodule

`default_nettype wire

//--- verilog.f
calc_pkg.sv
sign_mag_adder.sv
shift_add_multiplier.sv
calc_controller.sv
calc_top.sv
tb_calc.sv

//--- Bender.yml
package:
  name: calc

sources:
  - calc_pkg.sv
  - sign_mag_adder.sv
  - shift_add_multiplier.sv
  - calc_controller.sv
  - calc_top.sv
  - target: test
    files:
      - tb_calc.sv
